// File: logic/pcie_addr_dec_defines.svh
/* PCIe MM address decoder
   Bus widths, link count and the performance register map */
`ifndef PCIE_ADDR_DEC_DEFINES_SVH
`define PCIE_ADDR_DEC_DEFINES_SVH

`define MM_ADDR_W           17
`define DATA_W              64
`define NUM_LINKS           12
`define LINK_IDX_W          4       // Link field of the DPLBUF view
`define CSR_ADDR_W          14
`define LINK_OFS_W          12
`define PERF_ADDR_W         5       // Word index into the performance block
`define CNT_W               32

////////////////////////////////////////////////////////////
// Performance register word offsets
////////////////////////////////////////////////////////////
`define PERF_CTRL           5'd0    // Bit 0 written as 1 pulses the latch
`define PERF_SCRATCH        5'd1
`define PERF_TICKS          5'd2
`define PERF_SOP            5'd3
`define PERF_RDY_N          5'd4
`define PERF_CRED_BASE      5'd5    // P hdr, P data, NP hdr, NP data
`define PERF_LINK_REQ_BASE  5'd16   // One per link

`endif

// File: logic/pcie_addr_dec_pkg.sv
/* Shared MM types
   Data word and the two-way decoded MM address */
`default_nettype none

`include "pcie_addr_dec_defines.svh"

package pcie_addr_dec_pkg;

  typedef logic [`DATA_W-1:0] mm_word_t;

  // Top bit picks the region, the rest depends on it
  typedef union packed {
    struct packed {
      logic                                 is_dpl;     // Clear in global region
      logic [`MM_ADDR_W-`CSR_ADDR_W-3:0]    rsvd;
      logic                                 perf_sel;   // 1 = perf, 0 = CSR
      logic [`CSR_ADDR_W-1:0]               ofs;
    } glb;
    struct packed {
      logic                                 is_dpl;     // Set in DPLBUF region
      logic [`LINK_IDX_W-1:0]               link;
      logic [`LINK_OFS_W-1:0]               ofs;
    } dpl;
  } mm_addr_u;

endpackage

`default_nettype wire

// File: logic/pcie_mm_router.sv
/* MM region router
   Splits host accesses into global and DPLBUF regions, merges read returns */
`default_nettype none

module pcie_mm_router
(
  input  logic                          iCLK_PCIE_GLOBAL,
  input  logic                          iRST_N,
  input  pcie_addr_dec_pkg::mm_addr_u   iMM_ADDR,
  input  logic                          iMM_WR_EN,
  input  logic                          iMM_RD_EN,
  input  pcie_addr_dec_pkg::mm_word_t   iMM_WR_DATA,
  output pcie_addr_dec_pkg::mm_word_t   oMM_RD_DATA,
  output logic                          oMM_RD_DATA_V,
  output pcie_addr_dec_pkg::mm_addr_u   glb_addr,
  output logic                          glb_wr_en,
  output logic                          glb_rd_en,
  output pcie_addr_dec_pkg::mm_word_t   glb_wr_data,
  input  pcie_addr_dec_pkg::mm_word_t   glb_rd_data,
  input  logic                          glb_rd_data_v,
  output pcie_addr_dec_pkg::mm_addr_u   dpl_addr,
  output logic                          dpl_wr_en,
  output logic                          dpl_rd_en,
  output pcie_addr_dec_pkg::mm_word_t   dpl_wr_data,
  input  pcie_addr_dec_pkg::mm_word_t   dpl_rd_data,
  input  logic                          dpl_rd_data_v
);

  logic is_dpl;

  assign is_dpl = iMM_ADDR.dpl.is_dpl;      // Same bit in both views

  always_ff @(posedge iCLK_PCIE_GLOBAL or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      glb_wr_en     <= 1'b0;
      glb_rd_en     <= 1'b0;
      dpl_wr_en     <= 1'b0;
      dpl_rd_en     <= 1'b0;
      oMM_RD_DATA_V <= 1'b0;
    end
    else
    begin
      glb_wr_en     <= iMM_WR_EN & ~is_dpl;
      glb_rd_en     <= iMM_RD_EN & ~is_dpl;
      dpl_wr_en     <= iMM_WR_EN & is_dpl;
      dpl_rd_en     <= iMM_RD_EN & is_dpl;
      oMM_RD_DATA_V <= glb_rd_data_v | dpl_rd_data_v;   // One read in flight
    end
  end

  always_ff @(posedge iCLK_PCIE_GLOBAL)
  begin
    if (iMM_WR_EN || iMM_RD_EN)
    begin
      glb_addr    <= iMM_ADDR;
      dpl_addr    <= iMM_ADDR;
      glb_wr_data <= iMM_WR_DATA;
      dpl_wr_data <= iMM_WR_DATA;
    end
    if (glb_rd_data_v || dpl_rd_data_v)
      oMM_RD_DATA <= glb_rd_data_v ? glb_rd_data : dpl_rd_data;
  end

endmodule

`default_nettype wire

// File: logic/pcie_global_decoder.sv
/* Global region decoder
   Steers global accesses to the CSR block or the performance counters */
`default_nettype none

`include "pcie_addr_dec_defines.svh"

module pcie_global_decoder
(
  input  logic                          iCLK_PCIE_GLOBAL,
  input  logic                          iRST_N,
  input  pcie_addr_dec_pkg::mm_addr_u   glb_addr,
  input  logic                          glb_wr_en,
  input  logic                          glb_rd_en,
  input  pcie_addr_dec_pkg::mm_word_t   glb_wr_data,
  output pcie_addr_dec_pkg::mm_word_t   glb_rd_data,
  output logic                          glb_rd_data_v,
  output logic [`CSR_ADDR_W-1:0]        oPCIECTRL_ADDR,
  output pcie_addr_dec_pkg::mm_word_t   oPCIECTRL_WR_DATA,
  output logic                          oPCIECTRL_WR_EN,
  output logic                          oPCIECTRL_RD_EN,
  input  pcie_addr_dec_pkg::mm_word_t   iPCIECTRL_RD_DATA,
  input  logic                          iPCIECTRL_RD_DATA_V,
  output logic [`PERF_ADDR_W-1:0]       perf_addr,
  output logic                          perf_wr_en,
  output logic                          perf_rd_en,
  output pcie_addr_dec_pkg::mm_word_t   perf_wr_data,
  input  pcie_addr_dec_pkg::mm_word_t   perf_rd_data,
  input  logic                          perf_rd_data_v
);

  logic perf_sel;

  assign perf_sel = glb_addr.glb.perf_sel;   // Bit 14

  always_ff @(posedge iCLK_PCIE_GLOBAL or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      oPCIECTRL_WR_EN <= 1'b0;
      oPCIECTRL_RD_EN <= 1'b0;
      perf_wr_en      <= 1'b0;
      perf_rd_en      <= 1'b0;
      glb_rd_data_v   <= 1'b0;
    end
    else
    begin
      oPCIECTRL_WR_EN <= glb_wr_en & ~perf_sel;
      oPCIECTRL_RD_EN <= glb_rd_en & ~perf_sel;
      perf_wr_en      <= glb_wr_en & perf_sel;
      perf_rd_en      <= glb_rd_en & perf_sel;
      glb_rd_data_v   <= iPCIECTRL_RD_DATA_V | perf_rd_data_v;
    end
  end

  always_ff @(posedge iCLK_PCIE_GLOBAL)
  begin
    if (glb_wr_en || glb_rd_en)
    begin
      oPCIECTRL_ADDR    <= glb_addr.glb.ofs;
      perf_addr         <= glb_addr.glb.ofs[`PERF_ADDR_W-1:0];   // Word index only
      oPCIECTRL_WR_DATA <= glb_wr_data;
      perf_wr_data      <= glb_wr_data;
    end
    if (iPCIECTRL_RD_DATA_V || perf_rd_data_v)
      glb_rd_data <= perf_rd_data_v ? perf_rd_data : iPCIECTRL_RD_DATA;
  end

endmodule

`default_nettype wire

// File: logic/dplbuf_link_decoder.sv
/* DPLBUF link decoder
   One-hot fan-out to the link ports, zero answer for unmapped links */
`default_nettype none

`include "pcie_addr_dec_defines.svh"

module dplbuf_link_decoder
(
  input  logic                                          iCLK_PCIE_GLOBAL,
  input  logic                                          iRST_N,
  input  pcie_addr_dec_pkg::mm_addr_u                   dpl_addr,
  input  logic                                          dpl_wr_en,
  input  logic                                          dpl_rd_en,
  input  pcie_addr_dec_pkg::mm_word_t                   dpl_wr_data,
  output pcie_addr_dec_pkg::mm_word_t                   dpl_rd_data,
  output logic                                          dpl_rd_data_v,
  output logic [`NUM_LINKS-1:0][`LINK_OFS_W-1:0]        oDPLBUF_ADDR,
  output pcie_addr_dec_pkg::mm_word_t [`NUM_LINKS-1:0]  oDPLBUF_WR_DATA,
  output logic [`NUM_LINKS-1:0]                         oDPLBUF_WR_EN,
  output logic [`NUM_LINKS-1:0]                         oDPLBUF_RD_EN,
  input  pcie_addr_dec_pkg::mm_word_t [`NUM_LINKS-1:0]  iDPLBUF_RD_DATA,
  input  logic [`NUM_LINKS-1:0]                         iDPLBUF_RD_DATA_V
);

  import pcie_addr_dec_pkg::*;

  logic [`LINK_IDX_W-1:0]   link_idx;
  logic                     unmapped_rd;      // Stands in for the missing link
  mm_word_t                 link_data;

  assign link_idx = dpl_addr.dpl.link;

  // Only one link answers at a time
  always_comb
  begin
    link_data = '0;
    for (int i = 0; i < `NUM_LINKS; i++)
      if (iDPLBUF_RD_DATA_V[i])
        link_data = link_data | iDPLBUF_RD_DATA[i];
  end

  always_ff @(posedge iCLK_PCIE_GLOBAL or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      oDPLBUF_WR_EN <= '0;
      oDPLBUF_RD_EN <= '0;
      unmapped_rd   <= 1'b0;
      dpl_rd_data_v <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < `NUM_LINKS; i++)
      begin
        oDPLBUF_WR_EN[i] <= dpl_wr_en && link_idx == `LINK_IDX_W'(i);
        oDPLBUF_RD_EN[i] <= dpl_rd_en && link_idx == `LINK_IDX_W'(i);
      end
      unmapped_rd   <= dpl_rd_en && link_idx >= `LINK_IDX_W'(`NUM_LINKS);
      dpl_rd_data_v <= (|iDPLBUF_RD_DATA_V) | unmapped_rd;
    end
  end

  always_ff @(posedge iCLK_PCIE_GLOBAL)
  begin
    for (int i = 0; i < `NUM_LINKS; i++)
      if ((dpl_wr_en || dpl_rd_en) && link_idx == `LINK_IDX_W'(i))
      begin
        oDPLBUF_ADDR[i]    <= dpl_addr.dpl.ofs;
        oDPLBUF_WR_DATA[i] <= dpl_wr_data;
      end
    if ((|iDPLBUF_RD_DATA_V) || unmapped_rd)
      dpl_rd_data <= link_data;                  // Zero when unmapped
  end

endmodule

`default_nettype wire

// File: logic/pcie_perf_regs.sv
/* Performance counter bank
   Event counters with latch to snapshot, scratch word and read mux */
`default_nettype none

`include "pcie_addr_dec_defines.svh"

module pcie_perf_regs
(
  input  logic                                  iCLK_PCIE_GLOBAL,
  input  logic                                  iRST_N,
  input  logic [`PERF_ADDR_W-1:0]               perf_addr,
  input  logic                                  perf_wr_en,
  input  logic                                  perf_rd_en,
  input  pcie_addr_dec_pkg::mm_word_t           perf_wr_data,
  output pcie_addr_dec_pkg::mm_word_t           perf_rd_data,
  output logic                                  perf_rd_data_v,
  input  logic                                  sop_en,
  input  logic                                  rdy_n_en,
  input  logic [`NUM_LINKS-1:0]                 link_req_en,
  input  logic [3:0]                            cred_zero_ev,
  output logic                                  oPERF_LATCH,
  output logic [`NUM_LINKS-1:0][`CNT_W-1:0]     oPERF_REQ
);

  import pcie_addr_dec_pkg::*;

  localparam int NUM_CNT = 7 + `NUM_LINKS;    // Ticks, sop, rdy_n, 4 credit, links

  logic [NUM_CNT-1:0]               cnt_ev;
  logic [NUM_CNT-1:0][`CNT_W-1:0]   cnt;
  logic [NUM_CNT-1:0][`CNT_W-1:0]   snap;
  mm_word_t                         scratch;
  mm_word_t                         rd_word;

  // Register offset of counter idx
  function automatic logic [`PERF_ADDR_W-1:0] cnt_ofs(input int idx);
    int ofs;
    case (idx)
      0:          ofs = `PERF_TICKS;
      1:          ofs = `PERF_SOP;
      2:          ofs = `PERF_RDY_N;
      3, 4, 5, 6: ofs = `PERF_CRED_BASE + idx - 3;
      default:    ofs = `PERF_LINK_REQ_BASE + idx - 7;
    endcase
    return ofs[`PERF_ADDR_W-1:0];
  endfunction

  assign cnt_ev    = {link_req_en, cred_zero_ev, rdy_n_en, sop_en, 1'b1};  // Ticks always
  assign oPERF_REQ = snap[NUM_CNT-1:7];

  ////////////////////////////////////////////////////////////
  // Latch pulse and counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge iCLK_PCIE_GLOBAL or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      oPERF_LATCH <= 1'b0;
      cnt         <= '0;
      snap        <= '0;
    end
    else
    begin
      oPERF_LATCH <= perf_wr_en && perf_addr == `PERF_CTRL && perf_wr_data[0];
      for (int i = 0; i < NUM_CNT; i++)
      begin
        if (oPERF_LATCH)
        begin
          snap[i] <= cnt[i];
          cnt[i]  <= `CNT_W'(cnt_ev[i]);         // Restart with this cycle's event
        end
        else if (cnt_ev[i])
          cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge iCLK_PCIE_GLOBAL)
  begin
    if (perf_wr_en && perf_addr == `PERF_SCRATCH)
      scratch <= perf_wr_data;
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    rd_word = '0;                                 // Unmapped offsets
    if (perf_addr == `PERF_SCRATCH)
      rd_word = scratch;
    for (int i = 0; i < NUM_CNT; i++)
      if (perf_addr == cnt_ofs(i))
        rd_word = {{(`DATA_W-`CNT_W){1'b0}}, snap[i]};
  end

  always_ff @(posedge iCLK_PCIE_GLOBAL or negedge iRST_N)
  begin
    if (!iRST_N)
      perf_rd_data_v <= 1'b0;
    else
      perf_rd_data_v <= perf_rd_en;
  end

  always_ff @(posedge iCLK_PCIE_GLOBAL)
  begin
    if (perf_rd_en)
      perf_rd_data <= rd_word;
  end

endmodule

`default_nettype wire

// File: logic/pcie_cred_monitor.sv
/* Transmit credit monitor
   Two-stage registered zero detect on the posted and non-posted credits */
`default_nettype none

module pcie_cred_monitor
(
  input  logic          iCLK_PCIE_GLOBAL,
  input  logic          iRST_N,
  input  logic [7:0]    tx_cred_hdrfcp,
  input  logic [11:0]   tx_cred_datafcp,
  input  logic [7:0]    tx_cred_hdrfcnp,
  input  logic [11:0]   tx_cred_datafcnp,
  output logic [3:0]    cred_zero_ev          // P hdr, P data, NP hdr, NP data
);

  logic [3:0] zero_r;                         // First stage

  always_ff @(posedge iCLK_PCIE_GLOBAL or negedge iRST_N)
  begin
    if (!iRST_N)
    begin
      zero_r       <= '0;
      cred_zero_ev <= '0;
    end
    else
    begin
      zero_r[0]    <= tx_cred_hdrfcp == '0;
      zero_r[1]    <= tx_cred_datafcp == '0;
      zero_r[2]    <= tx_cred_hdrfcnp == '0;
      zero_r[3]    <= tx_cred_datafcnp == '0;
      cred_zero_ev <= zero_r;
    end
  end

endmodule

`default_nettype wire

// File: logic/pcie_addr_dec_wrap.sv
/* PCIe MM address decoder top
   Routes host MM accesses to CSR, performance counters and DPLBUF links */
`default_nettype none

`include "pcie_addr_dec_defines.svh"

module pcie_addr_dec_wrap
(
  input  logic                                          iCLK_PCIE_GLOBAL,
  input  logic                                          iRST_N,
  // MM
  input  pcie_addr_dec_pkg::mm_addr_u                   iMM_ADDR,
  input  logic                                          iMM_WR_EN,
  input  logic                                          iMM_RD_EN,
  input  pcie_addr_dec_pkg::mm_word_t                   iMM_WR_DATA,
  output pcie_addr_dec_pkg::mm_word_t                   oMM_RD_DATA,
  output logic                                          oMM_RD_DATA_V,
  // Control register block
  output logic [`CSR_ADDR_W-1:0]                        oPCIECTRL_ADDR,
  output pcie_addr_dec_pkg::mm_word_t                   oPCIECTRL_WR_DATA,
  output logic                                          oPCIECTRL_WR_EN,
  output logic                                          oPCIECTRL_RD_EN,
  input  pcie_addr_dec_pkg::mm_word_t                   iPCIECTRL_RD_DATA,
  input  logic                                          iPCIECTRL_RD_DATA_V,
  // DPLBUF links
  output logic [`NUM_LINKS-1:0][`LINK_OFS_W-1:0]        oDPLBUF_ADDR,
  output pcie_addr_dec_pkg::mm_word_t [`NUM_LINKS-1:0]  oDPLBUF_WR_DATA,
  output logic [`NUM_LINKS-1:0]                         oDPLBUF_WR_EN,
  output logic [`NUM_LINKS-1:0]                         oDPLBUF_RD_EN,
  input  pcie_addr_dec_pkg::mm_word_t [`NUM_LINKS-1:0]  iDPLBUF_RD_DATA,
  input  logic [`NUM_LINKS-1:0]                         iDPLBUF_RD_DATA_V,
  // Performance
  input  logic                                          iPERF_SOP_CTR,
  input  logic                                          iPERF_RDY_N,
  input  logic [`NUM_LINKS-1:0]                         iPERF_LINK_REQ,
  output logic                                          oPERF_LATCH,
  output logic [`NUM_LINKS-1:0][`CNT_W-1:0]             oPERF_REQ,
  // Transmit credits
  input  logic [7:0]                                    tx_cred_hdrfcp,
  input  logic [11:0]                                   tx_cred_datafcp,
  input  logic [7:0]                                    tx_cred_hdrfcnp,
  input  logic [11:0]                                   tx_cred_datafcnp
);

  import pcie_addr_dec_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////////////////////////
  mm_addr_u                   glb_addr;
  logic                       glb_wr_en;
  logic                       glb_rd_en;
  mm_word_t                   glb_wr_data;
  mm_word_t                   glb_rd_data;
  logic                       glb_rd_data_v;

  mm_addr_u                   dpl_addr;
  logic                       dpl_wr_en;
  logic                       dpl_rd_en;
  mm_word_t                   dpl_wr_data;
  mm_word_t                   dpl_rd_data;
  logic                       dpl_rd_data_v;

  logic [`PERF_ADDR_W-1:0]    perf_addr;
  logic                       perf_wr_en;
  logic                       perf_rd_en;
  mm_word_t                   perf_wr_data;
  mm_word_t                   perf_rd_data;
  logic                       perf_rd_data_v;

  logic [3:0]                 cred_zero_ev;     // Registered zero-credit flags

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////
  pcie_mm_router u_mm_router (.*);

  pcie_global_decoder u_global_dec (.*);

  dplbuf_link_decoder u_dplbuf_dec (.*);

  pcie_cred_monitor u_cred_mon (.*);

  pcie_perf_regs u_perf_regs
  (
    .*,
    .sop_en       (iPERF_SOP_CTR),
    .rdy_n_en     (iPERF_RDY_N),
    .link_req_en  (iPERF_LINK_REQ)
  );

endmodule

`default_nettype wire

// File: sim/pcie_addr_dec_assert.sv
/* Decoder strobe assertions
   Bound into the decoder top to watch the CSR, DPLBUF and latch strobes */
`default_nettype none

`include "pcie_addr_dec_defines.svh"

module pcie_addr_dec_assert
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    csr_wr_en,
  input  logic                    csr_rd_en,
  input  logic [`NUM_LINKS-1:0]   dpl_wr_en,
  input  logic [`NUM_LINKS-1:0]   dpl_rd_en,
  input  logic                    perf_latch
);

  csr_wr_rd_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(csr_wr_en && csr_rd_en))
    else $error("CSR write and read enables high together");

  dpl_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({dpl_wr_en, dpl_rd_en}))
    else $error("DPLBUF enables not one-hot");

  latch_single: assert property (@(posedge clk) disable iff (!rst_n)
    perf_latch |=> !perf_latch)
    else $error("Latch pulse longer than one cycle");

endmodule

bind pcie_addr_dec_wrap pcie_addr_dec_assert u_assert
(
  .clk        (iCLK_PCIE_GLOBAL),
  .rst_n      (iRST_N),
  .csr_wr_en  (oPCIECTRL_WR_EN),
  .csr_rd_en  (oPCIECTRL_RD_EN),
  .dpl_wr_en  (oDPLBUF_WR_EN),
  .dpl_rd_en  (oDPLBUF_RD_EN),
  .perf_latch (oPERF_LATCH)
);

`default_nettype wire

// File: sim/tb_clock_gen.sv
/* Testbench clock and reset
   Free-running clock, reset held low for a few cycles */
`default_nettype none

module tb_clock_gen
#(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 3
)
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;                              // Released on an edge
  end

endmodule

`default_nettype wire

// File: sim/tb_pcie_addr_dec.sv
/* Decoder testbench
   Random MM traffic with CSR and link responders and a counter model */
`default_nettype none

`include "pcie_addr_dec_defines.svh"

module tb_pcie_addr_dec;

  import pcie_addr_dec_pkg::*;

  localparam int       N_CSR    = 40;
  localparam int       N_DPL    = 60;
  localparam int       SPAN_MAX = 300;
  localparam int       NCNT     = 7 + `NUM_LINKS;
  localparam int       WD_CYC   = (N_CSR + N_DPL) * 2 * 16 + 2 * (SPAN_MAX + 200) + 200;
  localparam mm_word_t CSR_TAG  = 64'hC5A0_0000_0000_0000;
  localparam mm_word_t DPL_TAG  = 64'hD000_0000_0000_0000;

  logic clk;
  logic rst_n;

  mm_addr_u                                   iMM_ADDR = '0;
  logic                                       iMM_WR_EN = 1'b0;
  logic                                       iMM_RD_EN = 1'b0;
  mm_word_t                                   iMM_WR_DATA = '0;
  mm_word_t                                   oMM_RD_DATA;
  logic                                       oMM_RD_DATA_V;
  logic [`CSR_ADDR_W-1:0]                     oPCIECTRL_ADDR;
  mm_word_t                                   oPCIECTRL_WR_DATA;
  logic                                       oPCIECTRL_WR_EN;
  logic                                       oPCIECTRL_RD_EN;
  mm_word_t                                   iPCIECTRL_RD_DATA = '0;
  logic                                       iPCIECTRL_RD_DATA_V = 1'b0;
  logic [`NUM_LINKS-1:0][`LINK_OFS_W-1:0]     oDPLBUF_ADDR;
  mm_word_t [`NUM_LINKS-1:0]                  oDPLBUF_WR_DATA;
  logic [`NUM_LINKS-1:0]                      oDPLBUF_WR_EN;
  logic [`NUM_LINKS-1:0]                      oDPLBUF_RD_EN;
  mm_word_t [`NUM_LINKS-1:0]                  iDPLBUF_RD_DATA = '0;
  logic [`NUM_LINKS-1:0]                      iDPLBUF_RD_DATA_V = '0;
  logic                                       iPERF_SOP_CTR = 1'b0;
  logic                                       iPERF_RDY_N = 1'b0;
  logic [`NUM_LINKS-1:0]                      iPERF_LINK_REQ = '0;
  logic                                       oPERF_LATCH;
  logic [`NUM_LINKS-1:0][`CNT_W-1:0]          oPERF_REQ;
  logic [7:0]                                 tx_cred_hdrfcp = 8'hff;
  logic [11:0]                                tx_cred_datafcp = 12'hfff;
  logic [7:0]                                 tx_cred_hdrfcnp = 8'hff;
  logic [11:0]                                tx_cred_datafcnp = 12'hfff;

  int           errors = 0;
  int           n_tests = 0;
  int           n_failed = 0;
  logic         ev_run = 1'b0;
  logic         cred_run = 1'b0;

  // Responder state
  int                       csr_wait = 0;
  logic [`CSR_ADDR_W-1:0]   csr_rd_addr;
  int                       dpl_wait = 0;
  int                       dpl_link;
  logic [`LINK_OFS_W-1:0]   dpl_ofs;

  // Counter model, index 0 ticks, 1 sop, 2 rdy_n, 3..6 credits, 7.. links
  logic [`CNT_W-1:0]        m_cnt [NCNT];
  logic [`CNT_W-1:0]        m_snap [NCNT];
  logic [2:0]               m_lat_pipe;
  logic [3:0]               m_z1;
  logic [3:0]               m_z2;
  logic [NCNT-1:0]          m_ev;
  logic                     m_do_latch;

  tb_clock_gen #(.PERIOD(40), .RST_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

  pcie_addr_dec_wrap dut
  (
    .iCLK_PCIE_GLOBAL (clk),
    .iRST_N           (rst_n),
    .*
  );

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input mm_word_t exp, input mm_word_t act);
    if (act !== exp)
    begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [`CNT_W-1:0] exp,
                             input logic [`CNT_W-1:0] act);
    if (act !== exp)
    begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", what, exp, act);
    end
  endtask

  // Target bit NUM_LINKS is the CSR block
  // Address and data only mean something when a strobe is expected
  task automatic check_strobe(input string what,
                              input logic [`NUM_LINKS:0] exp_tgt, act_tgt,
                              input logic [`CSR_ADDR_W-1:0] exp_addr, act_addr,
                              input mm_word_t exp_data, act_data);
    if (act_tgt !== exp_tgt)
    begin
      errors++;
      $display("ERROR %s target: expected %h, actual %h", what, exp_tgt, act_tgt);
    end
    if (exp_tgt != '0)
    begin
      if (act_addr !== exp_addr)
      begin
        errors++;
        $display("ERROR %s address: expected %h, actual %h", what, exp_addr, act_addr);
      end
      check_word({what, " data"}, exp_data, act_data);
    end
  endtask

  function automatic mm_addr_u glb_addr(input logic perf, input logic [`CSR_ADDR_W-1:0] ofs);
    mm_addr_u a;
    a = '0;
    a.glb.perf_sel = perf;
    a.glb.ofs      = ofs;
    return a;
  endfunction

  function automatic mm_addr_u dpl_addr(input logic [3:0] link, input logic [`LINK_OFS_W-1:0] ofs);
    mm_addr_u a;
    a.dpl.is_dpl = 1'b1;
    a.dpl.link   = link;
    a.dpl.ofs    = ofs;
    return a;
  endfunction

  ////////////////////////////////////////////////////////////
  // MM driver
  ////////////////////////////////////////////////////////////
  task automatic mm_write(input mm_addr_u addr, input mm_word_t data);
    @(posedge clk);
    iMM_ADDR    <= addr;
    iMM_WR_DATA <= data;
    iMM_WR_EN   <= 1'b1;
    @(posedge clk);
    iMM_WR_EN   <= 1'b0;
  endtask

  task automatic mm_read(input mm_addr_u addr, output mm_word_t data, output int lat,
                         output logic [`NUM_LINKS:0] seen);
    int n;
    n    = 0;
    seen = '0;
    data = 'x;
    lat  = -1;
    @(posedge clk);
    iMM_ADDR  <= addr;
    iMM_RD_EN <= 1'b1;
    while (n < 40)
    begin
      @(posedge clk);
      if (n == 0)
        iMM_RD_EN <= 1'b0;
      n++;
      seen = seen | {oPCIECTRL_RD_EN, oDPLBUF_RD_EN};
      if (oMM_RD_DATA_V)
      begin
        data = oMM_RD_DATA;
        lat  = n - 1;                           // Valid rose one edge earlier
        break;
      end
    end
    if (lat < 0)
    begin
      errors++;
      $display("Read of address %h got no read data valid", addr);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    n_tests++;
    if (errors == err_before)
      $display("Test %s: PASS", name);
    else
    begin
      n_failed++;
      $display("Test %s: FAIL (%0d errors)", name, errors - err_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Responders and event drivers
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    iPCIECTRL_RD_DATA_V <= 1'b0;
    if (csr_wait > 0)
    begin
      csr_wait <= csr_wait - 1;
      if (csr_wait == 1)
      begin
        iPCIECTRL_RD_DATA_V <= 1'b1;
        iPCIECTRL_RD_DATA   <= CSR_TAG | mm_word_t'(csr_rd_addr);
      end
    end
    else if (oPCIECTRL_RD_EN)
    begin
      csr_wait    <= $urandom_range(4, 1);
      csr_rd_addr <= oPCIECTRL_ADDR;
    end
  end

  always @(posedge clk)
  begin
    iDPLBUF_RD_DATA_V <= '0;
    if (dpl_wait > 0)
    begin
      dpl_wait <= dpl_wait - 1;
      if (dpl_wait == 1)
      begin
        iDPLBUF_RD_DATA_V[dpl_link] <= 1'b1;
        iDPLBUF_RD_DATA[dpl_link]   <= DPL_TAG | (mm_word_t'(dpl_link) << 48)
                                       | mm_word_t'(dpl_ofs);
      end
    end
    else
      for (int i = 0; i < `NUM_LINKS; i++)
        if (oDPLBUF_RD_EN[i])
        begin
          dpl_wait <= $urandom_range(4, 1);
          dpl_link <= i;
          dpl_ofs  <= oDPLBUF_ADDR[i];
        end
  end

  always @(posedge clk)
  begin
    if (ev_run)
    begin
      iPERF_SOP_CTR  <= 1'($urandom);
      iPERF_RDY_N    <= 1'($urandom);
      iPERF_LINK_REQ <= `NUM_LINKS'($urandom);
    end
    if (cred_run)
    begin
      tx_cred_hdrfcp   <= $urandom_range(1, 0) ? 8'd0 : 8'($urandom);      // Zero half the time
      tx_cred_datafcp  <= $urandom_range(1, 0) ? 12'd0 : 12'($urandom);
      tx_cred_hdrfcnp  <= $urandom_range(1, 0) ? 8'd0 : 8'($urandom);
      tx_cred_datafcnp <= $urandom_range(1, 0) ? 12'd0 : 12'($urandom);
    end
  end

  ////////////////////////////////////////////////////////////
  // Counter model
  ////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NCNT; i++)
      begin
        m_cnt[i]  = '0;
        m_snap[i] = '0;
      end
      m_lat_pipe = '0;
      m_z1       = '0;
      m_z2       = '0;
    end
    else
    begin
      m_ev       = {iPERF_LINK_REQ, m_z2, iPERF_RDY_N, iPERF_SOP_CTR, 1'b1};
      m_do_latch = m_lat_pipe[2];              // Control write three edges ago
      if (oPERF_LATCH !== m_do_latch)
      begin
        errors++;
        $display("ERROR latch pulse: expected %b, actual %b", m_do_latch, oPERF_LATCH);
      end
      for (int i = 0; i < NCNT; i++)
        if (m_do_latch)
        begin
          m_snap[i] = m_cnt[i];
          m_cnt[i]  = `CNT_W'(m_ev[i]);
        end
        else
          m_cnt[i] = m_cnt[i] + `CNT_W'(m_ev[i]);
      m_lat_pipe = {m_lat_pipe[1:0], iMM_WR_EN && !iMM_ADDR.glb.is_dpl
                    && iMM_ADDR.glb.perf_sel && iMM_ADDR.glb.ofs[4:0] == `PERF_CTRL
                    && iMM_WR_DATA[0]};
      m_z2 = m_z1;
      m_z1 = {tx_cred_datafcnp == 0, tx_cred_hdrfcnp == 0,
              tx_cred_datafcp == 0, tx_cred_hdrfcp == 0};
    end
  end

  initial
  begin
    #(WD_CYC * 40);
    $display("Watchdog expired after %0d cycles, a test did not finish", WD_CYC);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  initial
  begin
    int                       e0;
    int                       lat;
    int                       link;
    int                       lk;
    int                       span;
    logic [`CSR_ADDR_W-1:0]   ofs;
    mm_word_t                 wd;
    mm_word_t                 rd;
    logic [`NUM_LINKS:0]      seen;
    logic [`NUM_LINKS:0]      tgt;

    void'($urandom(32'h3986306b));
    wait (rst_n);
    @(posedge clk);

    // CSR
    e0 = errors;
    for (int k = 0; k < N_CSR; k++)
    begin
      ofs = `CSR_ADDR_W'($urandom);
      wd  = {$urandom, $urandom};
      mm_write(glb_addr(1'b0, ofs), wd);
      repeat (2) @(posedge clk);
      check_strobe("csr write", 13'h1000, {oPCIECTRL_WR_EN, oDPLBUF_WR_EN},
                   ofs, oPCIECTRL_ADDR, wd, oPCIECTRL_WR_DATA);
      mm_read(glb_addr(1'b0, ofs), rd, lat, seen);
      check_word("csr read", CSR_TAG | mm_word_t'(ofs), rd);
    end
    end_test("csr_access", e0);

    // DPLBUF, links 12 to 15 unmapped
    e0 = errors;
    for (int k = 0; k < N_DPL; k++)
    begin
      link = $urandom_range(15, 0);
      lk   = (link < `NUM_LINKS) ? link : 0;
      ofs  = `CSR_ADDR_W'($urandom & 32'hfff);
      wd   = {$urandom, $urandom};
      tgt  = (link < `NUM_LINKS) ? 13'(1 << link) : '0;
      mm_write(dpl_addr(4'(link), `LINK_OFS_W'(ofs)), wd);
      repeat (2) @(posedge clk);
      check_strobe("dpl write", tgt, {oPCIECTRL_WR_EN, oDPLBUF_WR_EN},
                   ofs, `CSR_ADDR_W'(oDPLBUF_ADDR[lk]), wd, oDPLBUF_WR_DATA[lk]);
      mm_read(dpl_addr(4'(link), `LINK_OFS_W'(ofs)), rd, lat, seen);
      check_strobe("dpl read", tgt, seen,
                   ofs, `CSR_ADDR_W'(oDPLBUF_ADDR[lk]), wd, oDPLBUF_WR_DATA[lk]);
      if (link < `NUM_LINKS)
        check_word("dpl read", DPL_TAG | (mm_word_t'(link) << 48) | mm_word_t'(ofs), rd);
      else
      begin
        check_word("unmapped read", '0, rd);
        check_count("unmapped latency", 4, lat);
      end
    end
    end_test("dplbuf_access", e0);

    // Scratch
    e0 = errors;
    wd = {$urandom, $urandom};
    mm_write(glb_addr(1'b1, `PERF_SCRATCH), wd);
    mm_read(glb_addr(1'b1, `PERF_SCRATCH), rd, lat, seen);
    check_word("scratch read", wd, rd);
    check_count("scratch latency", 5, lat);
    end_test("scratch", e0);

    // Event counters
    e0     = errors;
    ev_run = 1'b1;
    span   = $urandom_range(SPAN_MAX, 50);
    repeat (span) @(posedge clk);
    mm_write(glb_addr(1'b1, `PERF_CTRL), 64'd1);
    repeat (8) @(posedge clk);
    for (int i = 0; i < 3; i++)
    begin
      mm_read(glb_addr(1'b1, `CSR_ADDR_W'(2 + i)), rd, lat, seen);
      check_word("ticks/sop/rdy_n count", {32'd0, m_snap[i]}, rd);
    end
    for (int i = 0; i < `NUM_LINKS; i++)
    begin
      mm_read(glb_addr(1'b1, `CSR_ADDR_W'(`PERF_LINK_REQ_BASE + i)), rd, lat, seen);
      check_word("link req count", {32'd0, m_snap[7 + i]}, rd);
      check_count("oPERF_REQ", m_snap[7 + i], oPERF_REQ[i]);
    end
    ev_run = 1'b0;
    end_test("counters", e0);

    // Zero credits
    e0       = errors;
    cred_run = 1'b1;
    span     = $urandom_range(SPAN_MAX, 50);
    repeat (span) @(posedge clk);
    mm_write(glb_addr(1'b1, `PERF_CTRL), 64'd1);
    repeat (8) @(posedge clk);
    for (int i = 0; i < 4; i++)
    begin
      mm_read(glb_addr(1'b1, `CSR_ADDR_W'(`PERF_CRED_BASE + i)), rd, lat, seen);
      check_word("zero credit count", {32'd0, m_snap[3 + i]}, rd);
    end
    cred_run = 1'b0;
    end_test("credits", e0);

    $display("Tests run %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0 && n_failed == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: pcie_addr_dec_wrap.f
+incdir+logic
logic/pcie_addr_dec_pkg.sv
logic/pcie_mm_router.sv
logic/pcie_global_decoder.sv
logic/dplbuf_link_decoder.sv
logic/pcie_perf_regs.sv
logic/pcie_cred_monitor.sv
logic/pcie_addr_dec_wrap.sv
sim/pcie_addr_dec_assert.sv
sim/tb_clock_gen.sv
sim/tb_pcie_addr_dec.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f pcie_addr_dec_wrap.f \
  --top-module tb_pcie_addr_dec \
  -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
